//--- hdc_assertions.sv
`timescale 1ns/100ps

module hdc_assertions (
    input logic                          clk,
    input logic                          arst_n,
    input logic                          instr_valid,
    input logic                          instr_bcast,
    input logic [hdc_pkg::LANE_BITS-1:0] instr_lane,
    input logic [hdc_pkg::OP_BITS-1:0]   instr_op,
    input logic                          bundle_read,
    input logic                          bundle_valid,
    input logic                          wr_en,
    input logic                          mem_wr,
    input logic [hdc_pkg::N_LANES-1:0]   fetch_v,
    input logic [hdc_pkg::N_LANES-1:0]   lane_store
);

    import hdc_pkg::*;

    // store is the effective op only with no lower bit set
    logic store_issued;

    // running count of assertion failures
    int fail_count = 0;

    assign store_issued = instr_valid && instr_op[OP_STORE] && (instr_op[OP_STORE-1:0] == '0);

    // a store pulse needs a matching store instruction three cycles back
    for (genvar i = 0; i < N_LANES; i++) begin : g_lane_chk
        a_store_src: assert property (@(posedge clk) disable iff (!arst_n)
            lane_store[i] |-> $past(store_issued &&
                (instr_bcast || instr_lane == LANE_BITS'(i)), 3))
            else begin
                $error("lane %0d stored without a store instruction three cycles before", i);
                fail_count++;
            end
    end

    // read pulse answered one cycle later
    a_read_valid: assert property (@(posedge clk) disable iff (!arst_n)
        bundle_read |=> bundle_valid)
        else begin
            $error("bundle_valid missing one cycle after bundle_read");
            fail_count++;
        end

    a_valid_read: assert property (@(posedge clk) disable iff (!arst_n)
        bundle_valid |-> $past(bundle_read))
        else begin
            $error("bundle_valid without bundle_read one cycle before");
            fail_count++;
        end

    // all strobes quiet while in reset
    a_reset_quiet: assert property (@(posedge clk)
        !arst_n |-> !(wr_en || mem_wr || (|fetch_v) || (|lane_store) || bundle_valid))
        else begin
            $error("strobe active during reset");
            fail_count++;
        end

endmodule

bind hdc_top hdc_assertions u_assertions (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr_valid  (instr_valid),
    .instr_bcast  (instr_bcast),
    .instr_lane   (instr_lane),
    .instr_op     (instr_op),
    .bundle_read  (bundle_read),
    .bundle_valid (bundle_valid),
    .wr_en        (wr_en),
    .mem_wr       (mem_wr),
    .fetch_v      (fetch_v),
    .lane_store   (lane_store)
);

//--- hdc_bundler.sv
`timescale 1ns/100ps
`default_nettype none

module hdc_bundler (
    input  wire logic                          clk,
    input  wire logic                          arst_n,
    // lane stores
    input  wire logic [hdc_pkg::N_LANES-1:0]   store,
    input  wire logic [hdc_pkg::HV_BITS-1:0]   result [hdc_pkg::N_LANES],
    // host control
    input  wire logic                          bundle_clear,
    input  wire logic                          bundle_read,
    // majority vector valid with the pulse
    output logic                               bundle_valid,
    output logic [hdc_pkg::HV_BITS-1:0]        bundle_out
);

    import hdc_pkg::*;

    // one counter per bit
    logic signed [COUNT_BITS-1:0] cnt [HV_BITS];

    // per-bit vote this cycle spans -N_LANES..N_LANES
    logic signed [LANE_BITS+1:0] delta [HV_BITS];

    // one extra bit so the sum cannot wrap
    logic signed [COUNT_BITS:0] sum_w [HV_BITS];
    logic signed [COUNT_BITS-1:0] cnt_next [HV_BITS];

    // positive counter means majority one
    logic [HV_BITS-1:0] majority;

    always_comb begin
        for (int b = 0; b < HV_BITS; b++) begin
            delta[b] = '0;
            // +1 for a one and -1 for a zero while idle lanes skip
            for (int i = 0; i < N_LANES; i++) begin
                if (store[i]) begin
                    delta[b] = result[i][b] ? delta[b] + 2'sd1 : delta[b] - 2'sd1;
                end
            end
            sum_w[b] = (COUNT_BITS + 1)'(cnt[b]) + (COUNT_BITS + 1)'(delta[b]);
            // clamp to the counter range
            if (sum_w[b] > COUNT_MAX) begin
                cnt_next[b] = COUNT_BITS'(COUNT_MAX);
            end else if (sum_w[b] < COUNT_MIN) begin
                cnt_next[b] = COUNT_BITS'(COUNT_MIN);
            end else begin
                cnt_next[b] = sum_w[b][COUNT_BITS-1:0];
            end
        end
    end

    // ties give zero
    always_comb begin
        for (int b = 0; b < HV_BITS; b++) begin
            majority[b] = !cnt[b][COUNT_BITS-1] && (cnt[b] != '0);
        end
    end

    // clear wins over a same-cycle store
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int b = 0; b < HV_BITS; b++) begin
                cnt[b] <= '0;
            end
        end else begin
            for (int b = 0; b < HV_BITS; b++) begin
                cnt[b] <= bundle_clear ? '0 : cnt_next[b];
            end
        end
    end

    // read port answers one cycle after bundle_read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bundle_valid <= 1'b0;
            bundle_out   <= '0;
        end else begin
            bundle_valid <= bundle_read;
            if (bundle_read) begin
                bundle_out <= majority;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdc_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

module hdc_dispatch (
    input  wire logic                          clk,
    input  wire logic                          arst_n,
    // item write from the generator
    input  wire logic                          wr_en,
    input  wire logic [hdc_pkg::ADDR_BITS-1:0] wr_addr,
    input  wire logic [hdc_pkg::HV_BITS-1:0]   wr_data,
    // host instruction
    input  wire logic                          instr_valid,
    input  wire logic                          instr_bcast,
    input  wire logic [hdc_pkg::LANE_BITS-1:0] instr_lane,
    input  wire logic [hdc_pkg::OP_BITS-1:0]   instr_op,
    input  wire logic [hdc_pkg::ADDR_BITS-1:0] instr_addr,
    // broadcast item write to every lane
    output logic                               mem_wr,
    output logic [hdc_pkg::ADDR_BITS-1:0]      mem_addr,
    output logic [hdc_pkg::HV_BITS-1:0]        mem_data,
    // per-lane fetch strobes, shared op and address
    output logic [hdc_pkg::N_LANES-1:0]        fetch_v,
    output logic [hdc_pkg::OP_BITS-1:0]        fetch_op,
    output logic [hdc_pkg::ADDR_BITS-1:0]      fetch_addr
);

    import hdc_pkg::*;

    // decoded lane select
    logic [N_LANES-1:0] lane_sel;

    // broadcast hits all lanes, else only the indexed one
    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            lane_sel[i] = instr_bcast || (instr_lane == LANE_BITS'(i));
        end
    end

    // item write stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wr   <= 1'b0;
            mem_addr <= '0;
            mem_data <= '0;
        end else begin
            mem_wr <= wr_en;
            if (wr_en) begin
                mem_addr <= wr_addr;
                mem_data <= wr_data;
            end
        end
    end

    // instruction stage
    // op and address held until the next instruction
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_v    <= '0;
            fetch_op   <= '0;
            fetch_addr <= '0;
        end else begin
            fetch_v <= instr_valid ? lane_sel : '0;
            if (instr_valid) begin
                fetch_op   <= instr_op;
                fetch_addr <= instr_addr;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdc_item_gen.sv
`timescale 1ns/100ps
`default_nettype none

module hdc_item_gen (
    input  wire logic                         clk,
    input  wire logic                         arst_n,
    // one write per strobe
    input  wire logic                         gen_wr,
    input  wire logic [hdc_pkg::ADDR_BITS-1:0] gen_addr,
    // registered item write
    output logic                              wr_en,
    output logic [hdc_pkg::ADDR_BITS-1:0]     wr_addr,
    output logic [hdc_pkg::HV_BITS-1:0]       wr_data
);

    import hdc_pkg::*;

    // xorshift state
    logic [HV_BITS-1:0] xs_q;
    logic [HV_BITS-1:0] xs_next;

    // xorshift64 step, shifts 13 / 7 / 17
    function automatic logic [HV_BITS-1:0] xorshift64(input logic [HV_BITS-1:0] x);
        logic [HV_BITS-1:0] t;
        t = x;
        t = t ^ (t << 13);
        t = t ^ (t >> 7);
        t = t ^ (t << 17);
        return t;
    endfunction

    assign xs_next = xorshift64(xs_q);

    // state only moves on a write
    // so item k is the k-th word after the seed
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            xs_q <= ITEM_SEED;
        end else if (gen_wr) begin
            xs_q <= xs_next;
        end
    end

    // write strobe one cycle after gen_wr
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_en   <= 1'b0;
            wr_addr <= '0;
            wr_data <= '0;
        end else begin
            wr_en <= gen_wr;
            // current word goes out, next one is prepared
            if (gen_wr) begin
                wr_addr <= gen_addr;
                wr_data <= xs_q;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdc_lane.sv
`timescale 1ns/100ps
`default_nettype none

module hdc_lane (
    input  wire logic                          clk,
    input  wire logic                          arst_n,
    // level, low clears working registers
    input  wire logic                          run,
    // item memory write port
    input  wire logic                          mem_wr,
    input  wire logic [hdc_pkg::ADDR_BITS-1:0] mem_addr,
    input  wire logic [hdc_pkg::HV_BITS-1:0]   mem_data,
    // fetch for this lane
    input  wire logic                          fetch_v,
    input  wire logic [hdc_pkg::OP_BITS-1:0]   fetch_op,
    input  wire logic [hdc_pkg::ADDR_BITS-1:0] fetch_addr,
    // store strobe and stored vector
    output logic                               store,
    output logic [hdc_pkg::HV_BITS-1:0]        result
);

    import hdc_pkg::*;

    // replicated item memory
    logic [HV_BITS-1:0] item_mem [ITEM_DEPTH];

    // stage one
    logic [HV_BITS-1:0] reg_0;
    logic [OP_BITS-1:0] op_r;
    logic               exec;

    // stage two working registers
    logic [HV_BITS-1:0] acc;
    logic [HV_BITS-1:0] held;

    // rotate right by one bit
    function automatic logic [HV_BITS-1:0] rot_r1(input logic [HV_BITS-1:0] x);
        return {x[0], x[HV_BITS-1:1]};
    endfunction

    // item writes, no reset on the array
    always_ff @(posedge clk) begin
        if (mem_wr) begin
            item_mem[mem_addr] <= mem_data;
        end
    end

    // read register, op and exec
    // fetches read memory even with run low
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_0 <= '0;
            op_r  <= '0;
            exec  <= 1'b0;
        end else begin
            exec <= fetch_v;
            if (fetch_v) begin
                reg_0 <= item_mem[fetch_addr];
                op_r  <= fetch_op;
            end
        end
    end

    // execute stage
    // registers hold between instructions
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc    <= '0;
            held   <= '0;
            store  <= 1'b0;
            result <= '0;
        end else begin
            // default, store is a one-cycle pulse
            store  <= 1'b0;
            result <= '0;
            if (!run) begin
                acc  <= '0;
                held <= '0;
            end else if (exec) begin
                // lowest set bit wins
                if (op_r[OP_LOAD]) begin
                    acc <= reg_0;
                end else if (op_r[OP_PERM_MEM]) begin
                    acc <= rot_r1(reg_0);
                end else if (op_r[OP_PERM_ACC]) begin
                    acc <= rot_r1(acc);
                end else if (op_r[OP_XOR_MEM]) begin
                    acc <= reg_0 ^ acc;
                end else if (op_r[OP_XOR_COPY]) begin
                    acc <= held ^ acc;
                end else if (op_r[OP_STORE]) begin
                    // acc out for one cycle
                    store  <= 1'b1;
                    result <= acc;
                end else if (op_r[OP_COPY]) begin
                    held <= acc;
                end else begin
                    // no op bit set
                    acc  <= '0;
                    held <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdc_pkg.sv
package hdc_pkg;

    // hypervector width
    localparam int HV_BITS = 64;

    // item memory per lane
    localparam int ITEM_DEPTH = 64;
    localparam int ADDR_BITS = $clog2(ITEM_DEPTH);

    // compute lanes
    localparam int N_LANES = 4;
    localparam int LANE_BITS = $clog2(N_LANES);

    // one-hot op field, lowest set bit wins
    localparam int OP_BITS = 7;
    localparam int OP_LOAD = 0;
    localparam int OP_PERM_MEM = 1;
    localparam int OP_PERM_ACC = 2;
    localparam int OP_XOR_MEM = 3;
    localparam int OP_XOR_COPY = 4;
    localparam int OP_STORE = 5;
    localparam int OP_COPY = 6;

    // bundler counters, signed and saturating
    localparam int COUNT_BITS = 8;
    localparam int COUNT_MAX = 2 ** (COUNT_BITS - 1) - 1;
    localparam int COUNT_MIN = -(2 ** (COUNT_BITS - 1));

    // xorshift64 start value, must not be zero
    // an all-zero state would lock the generator at zero
    localparam logic [HV_BITS-1:0] ITEM_SEED = 64'h9e37_79b9_7f4a_7c15;

endpackage

//--- hdc_tb.sv
`timescale 1ns/100ps

module hdc_tb;

    import hdc_pkg::*;

    // row kinds
    localparam int K_INSTR = 0;
    localparam int K_READ = 1;
    localparam int K_CLEAR = 2;
    localparam int K_RUN_LOW = 3;
    localparam int MAX_ROWS = 320;

    logic                 clk;
    logic                 arst_n;
    logic                 run;
    logic                 gen_wr;
    logic [ADDR_BITS-1:0] gen_addr;
    logic                 instr_valid;
    logic                 instr_bcast;
    logic [LANE_BITS-1:0] instr_lane;
    logic [OP_BITS-1:0]   instr_op;
    logic [ADDR_BITS-1:0] instr_addr;
    logic                 bundle_clear;
    logic                 bundle_read;
    logic [N_LANES-1:0]   lane_store;
    logic [HV_BITS-1:0]   lane_result [N_LANES];
    logic                 bundle_valid;
    logic [HV_BITS-1:0]   bundle_out;

    // stimulus table
    string                row_name [MAX_ROWS];
    int                   row_kind [MAX_ROWS];
    logic                 row_bcast [MAX_ROWS];
    logic [LANE_BITS-1:0] row_lane [MAX_ROWS];
    logic [OP_BITS-1:0]   row_op [MAX_ROWS];
    logic [ADDR_BITS-1:0] row_addr [MAX_ROWS];
    int                   n_rows = 0;

    // reference model of items, lane registers and bundler counters
    logic [HV_BITS-1:0] items [ITEM_DEPTH];
    logic [HV_BITS-1:0] m_acc [N_LANES];
    logic [HV_BITS-1:0] m_held [N_LANES];
    int                 m_cnt [HV_BITS];

    // expected stores per lane with the oldest at rd_ptr
    logic [HV_BITS-1:0] exp_val [N_LANES][512];
    int                 wr_ptr [N_LANES];
    int                 rd_ptr [N_LANES];

    int     errors = 0;
    int     test_start = 0;
    int     n_tests = 0;
    int     n_failed = 0;
    string  cur_test = "";
    integer seed = 32'hfc1;

    tb_clock_gen u_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    hdc_top dut0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .run          (run),
        .gen_wr       (gen_wr),
        .gen_addr     (gen_addr),
        .instr_valid  (instr_valid),
        .instr_bcast  (instr_bcast),
        .instr_lane   (instr_lane),
        .instr_op     (instr_op),
        .instr_addr   (instr_addr),
        .bundle_clear (bundle_clear),
        .bundle_read  (bundle_read),
        .lane_store   (lane_store),
        .lane_result  (lane_result),
        .bundle_valid (bundle_valid),
        .bundle_out   (bundle_out)
    );

    task automatic add_row(input string name, input int kind, input logic bcast,
                           input int lane, input int op, input int addr);
        row_name[n_rows] = name;
        row_kind[n_rows] = kind;
        row_bcast[n_rows] = bcast;
        row_lane[n_rows] = LANE_BITS'(lane);
        row_op[n_rows] = OP_BITS'(op);
        row_addr[n_rows] = ADDR_BITS'(addr);
        n_rows++;
    endtask

    // single-lane instruction with a one-hot op
    task automatic lane_op(input string name, input int lane, input int bit_pos, input int addr);
        add_row(name, K_INSTR, 1'b0, lane, 1 << bit_pos, addr);
    endtask

    function automatic int pending_stores();
        int n;
        n = 0;
        for (int l = 0; l < N_LANES; l++) n += wr_ptr[l] - rd_ptr[l];
        return n;
    endfunction

    // queue the expected store and vote it into the counters
    task automatic push_store(input int l);
        exp_val[l][wr_ptr[l]] = m_acc[l];
        wr_ptr[l]++;
        for (int b = 0; b < HV_BITS; b++) begin
            m_cnt[b] = m_cnt[b] + (m_acc[l][b] ? 1 : -1);
            if (m_cnt[b] > COUNT_MAX) m_cnt[b] = COUNT_MAX;
            if (m_cnt[b] < COUNT_MIN) m_cnt[b] = COUNT_MIN;
        end
    endtask

    task automatic model_exec(input int l, input logic [OP_BITS-1:0] op,
                              input logic [ADDR_BITS-1:0] addr);
        int first;
        // lowest set bit decides and none set means clear
        first = OP_BITS;
        for (int b = OP_BITS - 1; b >= 0; b--) if (op[b]) first = b;
        case (first)
            OP_LOAD: m_acc[l] = items[addr];
            OP_PERM_MEM: m_acc[l] = {items[addr][0], items[addr][HV_BITS-1:1]};
            OP_PERM_ACC: m_acc[l] = {m_acc[l][0], m_acc[l][HV_BITS-1:1]};
            OP_XOR_MEM: m_acc[l] = m_acc[l] ^ items[addr];
            OP_XOR_COPY: m_acc[l] = m_acc[l] ^ m_held[l];
            OP_STORE: push_store(l);
            OP_COPY: m_held[l] = m_acc[l];
            default: begin
                m_acc[l] = '0;
                m_held[l] = '0;
            end
        endcase
    endtask

    // one instruction per falling edge so rows go back to back
    task automatic issue(input int r);
        instr_valid = 1'b1;
        instr_bcast = row_bcast[r];
        instr_lane = row_lane[r];
        instr_op = row_op[r];
        instr_addr = row_addr[r];
        for (int l = 0; l < N_LANES; l++) begin
            if (row_bcast[r] || row_lane[r] == l) model_exec(l, row_op[r], row_addr[r]);
        end
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    // wait for every queued store to show up
    task automatic drain();
        bit done;
        done = 1'b0;
        for (int t = 0; t < 64 && !done; t++) begin
            @(posedge clk);
            done = (pending_stores() == 0);
        end
        assert (done) else begin
            $display("%s: expected lane stores did not arrive within 64 cycles", cur_test);
            errors++;
        end
        @(negedge clk);
    endtask

    task automatic read_bundle();
        logic [HV_BITS-1:0] exp;
        bit got;
        drain();
        // positive counter gives one and ties give zero
        for (int b = 0; b < HV_BITS; b++) exp[b] = (m_cnt[b] > 0);
        bundle_read = 1'b1;
        @(negedge clk);
        bundle_read = 1'b0;
        got = 1'b0;
        for (int t = 0; t < 8 && !got; t++) begin
            if (bundle_valid) got = 1'b1;
            else @(negedge clk);
        end
        assert (got) else begin
            $display("%s: bundle_valid never came after bundle_read", cur_test);
            errors++;
        end
        if (got) begin
            assert (bundle_out == exp) else begin
                $display("[FAIL] %s bundle expected %h actual %h", cur_test, exp, bundle_out);
                errors++;
            end
        end
        @(negedge clk);
    endtask

    task automatic clear_bundle();
        drain();
        bundle_clear = 1'b1;
        @(negedge clk);
        bundle_clear = 1'b0;
        for (int b = 0; b < HV_BITS; b++) m_cnt[b] = 0;
    endtask

    // run low for one cycle wipes acc and held in every lane
    task automatic drop_run();
        drain();
        run = 1'b0;
        @(negedge clk);
        run = 1'b1;
        for (int l = 0; l < N_LANES; l++) begin
            m_acc[l] = '0;
            m_held[l] = '0;
        end
    endtask

    task automatic end_test();
        drain();
        n_tests++;
        if (errors == test_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            n_failed++;
            $display("test %s: %0d errors", cur_test, errors - test_start);
        end
    endtask

    task automatic build_table();
        logic [31:0] r;
        int op;
        // lane k loads item k and stores it
        for (int k = 0; k < 8; k++) begin
            lane_op("items", k % N_LANES, OP_LOAD, k);
            lane_op("items", k % N_LANES, OP_STORE, 0);
        end
        lane_op("permute", 0, OP_PERM_MEM, 20);
        lane_op("permute", 0, OP_STORE, 0);
        lane_op("permute", 0, OP_PERM_ACC, 0);
        lane_op("permute", 0, OP_PERM_ACC, 0);
        lane_op("permute", 0, OP_PERM_ACC, 0);
        lane_op("permute", 0, OP_STORE, 0);
        // trigram with all six in flight back to back
        lane_op("ngram", 1, OP_PERM_MEM, 30);
        lane_op("ngram", 1, OP_COPY, 0);
        lane_op("ngram", 1, OP_PERM_MEM, 31);
        lane_op("ngram", 1, OP_XOR_COPY, 0);
        lane_op("ngram", 1, OP_XOR_MEM, 32);
        lane_op("ngram", 1, OP_STORE, 0);
        // four different vectors then a broadcast store
        for (int l = 0; l < N_LANES; l++) lane_op("bundle", l, OP_LOAD, 10 + l);
        add_row("bundle", K_CLEAR, 1'b0, 0, 0, 0);
        add_row("bundle", K_INSTR, 1'b1, 0, 1 << OP_STORE, 0);
        add_row("bundle", K_READ, 1'b0, 0, 0, 0);
        add_row("bundle", K_CLEAR, 1'b0, 0, 0, 0);
        add_row("bundle", K_READ, 1'b0, 0, 0, 0);
        // zero op on lane 2 and run low for lane 3
        // acc and held differ so a missed clear leaves a nonzero store
        lane_op("clear", 2, OP_LOAD, 40);
        lane_op("clear", 2, OP_COPY, 0);
        lane_op("clear", 2, OP_LOAD, 42);
        add_row("clear", K_INSTR, 1'b0, 2, 0, 0);
        lane_op("clear", 2, OP_XOR_COPY, 0);
        lane_op("clear", 2, OP_STORE, 0);
        lane_op("clear", 3, OP_LOAD, 41);
        lane_op("clear", 3, OP_COPY, 0);
        lane_op("clear", 3, OP_LOAD, 43);
        add_row("clear", K_RUN_LOW, 1'b0, 0, 0, 0);
        lane_op("clear", 3, OP_XOR_COPY, 0);
        lane_op("clear", 3, OP_STORE, 0);
        for (int n = 0; n < 200; n++) begin
            r = $random(seed);
            op = 1 << ($unsigned($random(seed)) % OP_BITS);
            // an extra high bit now and then where the lower bit must still win
            if (r[7:5] == 3'd0) op = op | (1 << OP_COPY);
            add_row("random", K_INSTR, r[4:2] == 3'd0, r[1:0], op,
                    $random(seed) & (ITEM_DEPTH - 1));
        end
    endtask

    // store monitor samples once outputs settle past the rising edge
    always @(negedge clk) begin
        if (arst_n) begin
            for (int l = 0; l < N_LANES; l++) begin
                if (lane_store[l]) begin
                    assert (rd_ptr[l] < wr_ptr[l]) else begin
                        $display("%s: lane %0d stored with nothing expected", cur_test, l);
                        errors++;
                    end
                    if (rd_ptr[l] < wr_ptr[l]) begin
                        assert (lane_result[l] == exp_val[l][rd_ptr[l]]) else begin
                            $display("[FAIL] %s lane %0d expected %h actual %h", cur_test, l,
                                     exp_val[l][rd_ptr[l]], lane_result[l]);
                            errors++;
                        end
                        rd_ptr[l]++;
                    end
                end
            end
        end
    end

    initial begin
        logic [HV_BITS-1:0] state;
        bit rst_done;
        run = 1'b1;
        gen_wr = 1'b0;
        gen_addr = '0;
        instr_valid = 1'b0;
        instr_bcast = 1'b0;
        instr_lane = '0;
        instr_op = '0;
        instr_addr = '0;
        bundle_clear = 1'b0;
        bundle_read = 1'b0;
        for (int l = 0; l < N_LANES; l++) begin
            wr_ptr[l] = 0;
            rd_ptr[l] = 0;
            m_acc[l] = '0;
            m_held[l] = '0;
        end
        for (int b = 0; b < HV_BITS; b++) m_cnt[b] = 0;
        rst_done = 1'b0;
        for (int t = 0; t < 40 && !rst_done; t++) begin
            @(negedge clk);
            rst_done = (arst_n === 1'b1);
        end
        assert (rst_done) else begin
            $display("reset was not released within 40 cycles");
            errors++;
        end
        // item a is the xorshift word after a steps
        state = ITEM_SEED;
        for (int a = 0; a < ITEM_DEPTH; a++) begin
            gen_wr = 1'b1;
            gen_addr = ADDR_BITS'(a);
            items[a] = state;
            state = state ^ (state << 13);
            state = state ^ (state >> 7);
            state = state ^ (state << 17);
            @(negedge clk);
        end
        gen_wr = 1'b0;
        // last write reaches the lane memories a few edges later
        repeat (3) @(negedge clk);
        build_table();
        for (int r = 0; r < n_rows; r++) begin
            if (row_name[r] != cur_test) begin
                if (cur_test != "") end_test();
                cur_test = row_name[r];
                test_start = errors;
            end
            case (row_kind[r])
                K_INSTR: issue(r);
                K_READ: read_bundle();
                K_CLEAR: clear_bundle();
                default: drop_run();
            endcase
        end
        end_test();
        if (dut0.u_assertions.fail_count != 0) begin
            $display("%0d concurrent assertions failed in the bound checker",
                     dut0.u_assertions.fail_count);
            errors += dut0.u_assertions.fail_count;
        end
        $display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- hdc_top.sv
`timescale 1ns/100ps
`default_nettype none

module hdc_top (
    input  wire logic                          clk,
    input  wire logic                          arst_n,
    input  wire logic                          run,
    // item generation
    input  wire logic                          gen_wr,
    input  wire logic [hdc_pkg::ADDR_BITS-1:0] gen_addr,
    // host instructions
    input  wire logic                          instr_valid,
    input  wire logic                          instr_bcast,
    input  wire logic [hdc_pkg::LANE_BITS-1:0] instr_lane,
    input  wire logic [hdc_pkg::OP_BITS-1:0]   instr_op,
    input  wire logic [hdc_pkg::ADDR_BITS-1:0] instr_addr,
    // bundler control
    input  wire logic                          bundle_clear,
    input  wire logic                          bundle_read,
    // lane store strobes and their vectors
    output logic [hdc_pkg::N_LANES-1:0]        lane_store,
    output logic [hdc_pkg::HV_BITS-1:0]        lane_result [hdc_pkg::N_LANES],
    output logic                               bundle_valid,
    output logic [hdc_pkg::HV_BITS-1:0]        bundle_out
);

    import hdc_pkg::*;

    // generator to dispatcher
    logic                 wr_en;
    logic [ADDR_BITS-1:0] wr_addr;
    logic [HV_BITS-1:0]   wr_data;

    // dispatcher to lanes
    logic                 mem_wr;
    logic [ADDR_BITS-1:0] mem_addr;
    logic [HV_BITS-1:0]   mem_data;
    logic [N_LANES-1:0]   fetch_v;
    logic [OP_BITS-1:0]   fetch_op;
    logic [ADDR_BITS-1:0] fetch_addr;

    hdc_item_gen u_item_gen (
        .clk      (clk),
        .arst_n   (arst_n),
        .gen_wr   (gen_wr),
        .gen_addr (gen_addr),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    hdc_dispatch u_dispatch (
        .clk         (clk),
        .arst_n      (arst_n),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .instr_valid (instr_valid),
        .instr_bcast (instr_bcast),
        .instr_lane  (instr_lane),
        .instr_op    (instr_op),
        .instr_addr  (instr_addr),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .fetch_v     (fetch_v),
        .fetch_op    (fetch_op),
        .fetch_addr  (fetch_addr)
    );

    // identical lanes, each with its own fetch strobe
    for (genvar i = 0; i < N_LANES; i++) begin : g_lane
        hdc_lane u_lane (
            .clk        (clk),
            .arst_n     (arst_n),
            .run        (run),
            .mem_wr     (mem_wr),
            .mem_addr   (mem_addr),
            .mem_data   (mem_data),
            .fetch_v    (fetch_v[i]),
            .fetch_op   (fetch_op),
            .fetch_addr (fetch_addr),
            .store      (lane_store[i]),
            .result     (lane_result[i])
        );
    end

    hdc_bundler u_bundler (
        .clk          (clk),
        .arst_n       (arst_n),
        .store        (lane_store),
        .result       (lane_result),
        .bundle_clear (bundle_clear),
        .bundle_read  (bundle_read),
        .bundle_valid (bundle_valid),
        .bundle_out   (bundle_out)
    );

endmodule

`default_nettype wire

//--- list.f
hdc_pkg.sv
hdc_item_gen.sv
hdc_dispatch.sv
hdc_lane.sv
hdc_bundler.sv
hdc_top.sv
tb_clock_gen.sv
hdc_assertions.sv
hdc_tb.sv

//--- tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset falls just after time zero so every flop sees the edge
    // held for 10 cycles and released on a falling edge away from the sampling edge
    initial begin
        arst_n = 1'b1;
        #1;
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule
